/* source/basics_defs.svh */
`ifndef BASICS_DEFS_SVH
`define BASICS_DEFS_SVH

// Version the node reports on a query and expects on a version check
`define BASICS_VERSION_MAJOR 8'h01
`define BASICS_VERSION_MINOR 8'h03

// Request addresses the node answers to
`define BASICS_ADDR_QUERY 8'h56
`define BASICS_ADDR_VERSION 8'h76

// First byte of an acknowledge frame
`define BASICS_CODE_ACK 8'h06

// First byte of a negative acknowledge frame
`define BASICS_CODE_NAK 8'h15

// Reply bytes the output FIFO can hold before it drops writes
`define BASICS_FIFO_DEPTH 16

`endif

/* source/basics_pkg.sv */
`default_nettype none

package basics_pkg;

	// One byte on either message bus
	typedef logic [7:0] msg_byte_t;

	// One cycle of the reply stream into the output FIFO
	// The frame bit stays high from the first to the last byte of a reply
	typedef struct packed {
		msg_byte_t data;
		logic latch;
		logic frame;
	} msg_beat_t;

	// Request kinds seen at frame start
	typedef struct packed {
		logic version;
		logic query;
		logic nak;
	} command_t;

	// Request handling steps of the responder
	typedef enum logic [3:0] {
		st_idle,
		st_take_eid,
		st_send_nak,
		st_send_query_ack,
		st_take_version,
		st_judge_version,
		st_wait_ack,
		st_send_major,
		st_send_minor
	} resp_state_t;

endpackage

`default_nettype wire

/* source/ack_generator.sv */
`default_nettype none
`include "basics_defs.svh"

module ack_generator import basics_pkg::*; (
	input wire logic clk,
	input wire logic rst,

	// One-cycle requests for a reply frame
	input wire logic generate_ack,
	input wire logic generate_nak,
	input wire msg_byte_t eid,

	output msg_beat_t beat
);

	// Step one sends the code byte and step two the EID
	logic [1:0] step;
	msg_byte_t code_q;
	msg_byte_t eid_q;
	logic start;

	assign start = generate_ack || generate_nak;

	always_ff @(posedge clk) begin
		if (rst) begin
			step <= 2'd0;
		end else if (start) begin
			step <= 2'd1;
		end else if (step == 2'd1) begin
			step <= 2'd2;
		end else begin
			step <= 2'd0;
		end
	end

	// Code and EID are captured with the pulse so the caller may move on
	always_ff @(posedge clk) begin
		if (start) begin
			code_q <= generate_nak ? `BASICS_CODE_NAK : `BASICS_CODE_ACK;
			eid_q <= eid;
		end
	end

	always_comb begin
		beat.data = (step == 2'd2) ? eid_q : code_q;
		beat.latch = (step != 2'd0);
		beat.frame = (step != 2'd0);
	end

	// A request asks for exactly one kind of reply
	a_one_kind: assert property (@(posedge clk) disable iff (rst)
		!(generate_ack && generate_nak));

	// The responder waits for the frame to close before it asks again
	a_no_restart: assert property (@(posedge clk) disable iff (rst)
		(step != 2'd0) |-> !start);

endmodule

`default_nettype wire

/* source/message_fifo.sv */
`default_nettype none
`include "basics_defs.svh"

module message_fifo import basics_pkg::*; #(
	parameter int DEPTH = `BASICS_FIFO_DEPTH
) (
	input wire logic clk,
	input wire logic rst,

	// Reply bytes and frame boundaries
	input wire msg_beat_t in_beat,
	output logic overflow,

	// Arbitrated output side
	output msg_byte_t out_data,
	output logic out_request,
	input wire logic out_latch
);

	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	// Payload bytes, and one length entry per committed frame
	msg_byte_t mem [DEPTH];
	msg_byte_t len_mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] len_wr_ptr;
	logic [AW-1:0] len_rd_ptr;
	logic [CW-1:0] used;
	logic [CW-1:0] frames;
	msg_byte_t frame_len;
	msg_byte_t rd_left;
	logic frame_q;
	logic rd_payload;

	logic wr_en;
	logic commit;
	logic rd_en;
	logic rd_done;

	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign wr_en = in_beat.latch && (used != CW'(DEPTH));
	assign overflow = in_beat.latch && !wr_en;

	// The falling frame bit closes the frame that is being written
	assign commit = frame_q && !in_beat.frame;

	assign rd_en = out_latch && (frames != '0);
	assign rd_done = rd_en && rd_payload && (rd_left == 8'd1);

	// The length byte goes out first, then the payload
	assign out_data = rd_payload ? mem[rd_ptr] : len_mem[len_rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= in_beat.data;
		end
		if (commit) begin
			len_mem[len_wr_ptr] <= frame_len;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en && !rd_payload) begin
			rd_left <= len_mem[len_rd_ptr];
		end else if (rd_en) begin
			rd_left <= rd_left - 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			len_wr_ptr <= '0;
			len_rd_ptr <= '0;
			used <= '0;
			frames <= '0;
			frame_len <= '0;
			frame_q <= 1'b0;
			rd_payload <= 1'b0;
			out_request <= 1'b0;
		end else begin
			frame_q <= in_beat.frame;
			if (wr_en) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (commit) begin
				frame_len <= '0;
				len_wr_ptr <= ptr_inc(len_wr_ptr);
			end else if (wr_en) begin
				frame_len <= frame_len + 8'd1;
			end
			if (rd_en && !rd_payload) begin
				rd_payload <= 1'b1;
			end else if (rd_en) begin
				rd_ptr <= ptr_inc(rd_ptr);
				if (rd_done) begin
					rd_payload <= 1'b0;
					len_rd_ptr <= ptr_inc(len_rd_ptr);
				end
			end
			used <= used + CW'(wr_en) - CW'(rd_en && rd_payload);
			frames <= frames + CW'(commit) - CW'(rd_done);
			// The request drops for one cycle after every frame so the arbiter can rotate
			out_request <= !rd_done && (commit || (frames != '0));
		end
	end

	// The arbiter only takes bytes while a committed frame waits
	a_no_empty_read: assert property (@(posedge clk) disable iff (rst)
		out_latch |-> (frames != '0));

	// Every committed frame holds at least one stored byte
	a_nonzero_len: assert property (@(posedge clk) disable iff (rst)
		$fell(in_beat.frame) |-> (frame_len != '0));

endmodule

`default_nettype wire

/* source/basics_responder.sv */
`default_nettype none
`include "basics_defs.svh"

module basics_responder import basics_pkg::*; (
	input wire logic clk,
	input wire logic rst,

	// Master input bus
	input wire logic generate_nak,
	input wire logic ma_data_valid,
	input wire logic ma_frame_valid,
	input wire msg_byte_t ma_data,

	// Reply side, with the latch already qualified by grant
	output msg_byte_t sl_data,
	output logic sl_arb_request,
	output logic overflow,
	input wire logic sl_latch
);

	resp_state_t state;
	resp_state_t next_state;
	command_t command;
	command_t new_command;
	msg_byte_t eid_q;
	logic [15:0] version_q;
	logic byte_idx;
	logic frame_q;
	logic frame_start;

	logic ag_ack;
	logic ag_nak;
	msg_beat_t ag_beat;
	msg_beat_t local_beat;
	msg_beat_t fifo_beat;

	// The address byte is on the bus in the cycle where the frame rises
	assign frame_start = ma_frame_valid && !frame_q;

	always_comb begin
		new_command.version = frame_start && (ma_data == `BASICS_ADDR_VERSION);
		new_command.query = frame_start && (ma_data == `BASICS_ADDR_QUERY);
		new_command.nak = frame_start && generate_nak;
	end

	always_comb begin
		next_state = state;
		ag_ack = 1'b0;
		ag_nak = 1'b0;
		local_beat.data = `BASICS_VERSION_MAJOR;
		local_beat.latch = 1'b0;
		local_beat.frame = 1'b0;
		case (state)
			st_idle: begin
				if (new_command != '0) begin
					next_state = st_take_eid;
				end
			end
			// First data byte is the length and is skipped, the second is the EID
			st_take_eid: begin
				if (!ma_frame_valid) begin
					next_state = st_idle;
				end else if (ma_data_valid && byte_idx) begin
					if (command.nak) begin
						next_state = st_send_nak;
					end else if (command.query) begin
						next_state = st_send_query_ack;
					end else begin
						next_state = st_take_version;
					end
				end
			end
			st_send_nak: begin
				ag_nak = 1'b1;
				next_state = st_idle;
			end
			st_send_query_ack: begin
				ag_ack = 1'b1;
				next_state = st_wait_ack;
			end
			st_take_version: begin
				if (!ma_frame_valid) begin
					next_state = st_idle;
				end else if (ma_data_valid && byte_idx) begin
					next_state = st_judge_version;
				end
			end
			st_judge_version: begin
				if (version_q == {`BASICS_VERSION_MAJOR, `BASICS_VERSION_MINOR}) begin
					ag_ack = 1'b1;
					next_state = st_idle;
				end else begin
					ag_nak = 1'b1;
					next_state = st_wait_ack;
				end
			end
			// The version frame opens only after the acknowledge frame has been committed
			st_wait_ack: begin
				if (!ag_beat.frame) begin
					next_state = st_send_major;
				end
			end
			st_send_major: begin
				local_beat.latch = 1'b1;
				local_beat.frame = 1'b1;
				next_state = st_send_minor;
			end
			st_send_minor: begin
				local_beat.data = `BASICS_VERSION_MINOR;
				local_beat.latch = 1'b1;
				local_beat.frame = 1'b1;
				next_state = st_idle;
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			command <= '0;
			frame_q <= 1'b0;
			byte_idx <= 1'b0;
		end else begin
			state <= next_state;
			frame_q <= ma_frame_valid;
			if (state == st_idle) begin
				command <= new_command;
			end
			if (next_state != state) begin
				byte_idx <= 1'b0;
			end else if (ma_data_valid) begin
				byte_idx <= !byte_idx;
			end
		end
	end

	always_ff @(posedge clk) begin
		if ((state == st_take_eid) && ma_data_valid && byte_idx) begin
			eid_q <= ma_data;
		end
		if ((state == st_take_version) && ma_data_valid) begin
			version_q <= {version_q[7:0], ma_data};
		end
	end

	// Only one source writes in any cycle so the latch bits can be merged
	always_comb begin
		fifo_beat.data = ag_beat.latch ? ag_beat.data : local_beat.data;
		fifo_beat.latch = ag_beat.latch || local_beat.latch;
		fifo_beat.frame = ag_beat.frame || local_beat.frame;
	end

	ack_generator u_ack_generator (
		.clk (clk),
		.rst (rst),
		.generate_ack (ag_ack),
		.generate_nak (ag_nak),
		.eid (eid_q),
		.beat (ag_beat)
	);

	message_fifo #(
		.DEPTH (`BASICS_FIFO_DEPTH)
	) u_message_fifo (
		.clk (clk),
		.rst (rst),
		.in_beat (fifo_beat),
		.overflow (overflow),
		.out_data (sl_data),
		.out_request (sl_arb_request),
		.out_latch (sl_latch)
	);

	// The version payload path is taken only for a version request without a NAK
	a_version_cmd: assert property (@(posedge clk) disable iff (rst)
		(state == st_take_version) |-> (command.version && !command.nak));

endmodule

`default_nettype wire

/* source/basics_node.sv */
`default_nettype none

module basics_node import basics_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic generate_nak,
	input wire logic ma_data_valid,
	input wire logic ma_frame_valid,
	input wire msg_byte_t ma_data,
	input wire logic sl_arb_grant,
	input wire logic sl_data_latch,
	output logic sl_arb_request,
	output logic overflow,
	inout wire msg_byte_t sl_data
);

	msg_byte_t resp_data;
	logic resp_latch;

	// The shared bus is driven and read only while this node holds the grant
	assign resp_latch = sl_data_latch && sl_arb_grant;
	assign sl_data = sl_arb_grant ? resp_data : 'z;

	basics_responder u_basics_responder (
		.clk (clk),
		.rst (rst),
		.generate_nak (generate_nak),
		.ma_data_valid (ma_data_valid),
		.ma_frame_valid (ma_frame_valid),
		.ma_data (ma_data),
		.sl_data (resp_data),
		.sl_arb_request (sl_arb_request),
		.overflow (overflow),
		.sl_latch (resp_latch)
	);

endmodule

`default_nettype wire

/* verif/basics_tb.sv */
`default_nettype none
`include "basics_defs.svh"

module basics_tb import basics_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;
	localparam int N_RANDOM = 20;
	// Five directed frames, the random ones and four held behind a withheld grant
	localparam int N_FRAMES = 5 + N_RANDOM + 4;

	logic clk;
	logic rst;
	logic generate_nak;
	logic ma_data_valid;
	logic ma_frame_valid;
	msg_byte_t ma_data;
	logic sl_arb_grant;
	logic sl_data_latch;
	logic sl_arb_request;
	logic overflow;
	tri1 [7:0] sl_data;

	integer seed = 32'hb5f6_c006;
	integer arb_seed = ~32'hb5f6_c006;
	logic hold_grant;
	msg_byte_t tx_bytes [8];
	int tx_count;
	msg_byte_t exp_q [$];
	msg_byte_t got_q [$];

	basics_node u_basics_node (
		.clk (clk),
		.rst (rst),
		.generate_nak (generate_nak),
		.ma_data_valid (ma_data_valid),
		.ma_frame_valid (ma_frame_valid),
		.ma_data (ma_data),
		.sl_arb_grant (sl_arb_grant),
		.sl_data_latch (sl_data_latch),
		.sl_arb_request (sl_arb_request),
		.overflow (overflow),
		.sl_data (sl_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_byte(input msg_byte_t got, input msg_byte_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_idle(input logic level, input string what);
		if (level !== 1'b0) begin
			$display("CHECK FAILED at %0t: %s is %b, expected low", $time, what, level);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	// Each reply frame is a length byte followed by two bytes
	function automatic void push_frame(input msg_byte_t first, input msg_byte_t second);
		exp_q.push_back(8'd2);
		exp_q.push_back(first);
		exp_q.push_back(second);
	endfunction

	function automatic void ref_reply(input logic nak, input msg_byte_t addr,
			input msg_byte_t eid, input msg_byte_t major, input msg_byte_t minor);
		if (nak) begin
			push_frame(`BASICS_CODE_NAK, eid);
		end else if (addr == `BASICS_ADDR_QUERY) begin
			push_frame(`BASICS_CODE_ACK, eid);
			push_frame(`BASICS_VERSION_MAJOR, `BASICS_VERSION_MINOR);
		end else if (addr == `BASICS_ADDR_VERSION) begin
			if (major == `BASICS_VERSION_MAJOR && minor == `BASICS_VERSION_MINOR) begin
				push_frame(`BASICS_CODE_ACK, eid);
			end else begin
				push_frame(`BASICS_CODE_NAK, eid);
				push_frame(`BASICS_VERSION_MAJOR, `BASICS_VERSION_MINOR);
			end
		end
	endfunction

	// Address cycle first, then the bytes in tx_bytes, then a quiet gap on the bus
	task automatic drive_frame(input logic nak, input msg_byte_t addr);
		int j;
		@(posedge clk);
		ma_frame_valid <= 1'b1;
		ma_data <= addr;
		generate_nak <= nak;
		for (j = 0; j < tx_count; j++) begin
			@(posedge clk);
			generate_nak <= 1'b0;
			ma_data_valid <= 1'b1;
			ma_data <= tx_bytes[j];
		end
		@(posedge clk);
		ma_frame_valid <= 1'b0;
		ma_data_valid <= 1'b0;
		ma_data <= '0;
		repeat (12) @(posedge clk);
	endtask

	// Kinds: 0 NAK, 1 query, 2 matching version, 3 wrong version, 4 foreign address
	task automatic run_request(input int kind);
		msg_byte_t addr;
		msg_byte_t major;
		msg_byte_t minor;
		logic nak;
		int j;
		nak = 1'b0;
		addr = $random(seed);
		major = `BASICS_VERSION_MAJOR;
		minor = `BASICS_VERSION_MINOR;
		tx_bytes[1] = $random(seed);
		tx_count = 2;
		case (kind)
			0: nak = 1'b1;
			1: addr = `BASICS_ADDR_QUERY;
			2, 3: begin
				addr = `BASICS_ADDR_VERSION;
				if (kind == 3) begin
					major = $random(seed);
					minor = $random(seed);
					if (major == `BASICS_VERSION_MAJOR && minor == `BASICS_VERSION_MINOR)
						minor = minor ^ 8'h01;
				end
				tx_bytes[2] = major;
				tx_bytes[3] = minor;
				tx_count = 4;
			end
			default: begin
				if (addr == `BASICS_ADDR_QUERY || addr == `BASICS_ADDR_VERSION)
					addr = addr ^ 8'h80;
				tx_count = 2 + $unsigned($random(seed)) % 3;
				for (j = 2; j < tx_count; j++)
					tx_bytes[j] = $random(seed);
			end
		endcase
		tx_bytes[0] = tx_count - 1;
		ref_reply(nak, addr, tx_bytes[1], major, minor);
		drive_frame(nak, addr);
	endtask

	task automatic wait_replies_done();
		while (exp_q.size() != 0 || got_q.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);
		check_idle(sl_arb_request, "sl_arb_request after all replies");
	endtask

	// Bus arbiter model, reads the length byte and then that many payload bytes
	initial begin : arbiter
		msg_byte_t b;
		int left;
		logic first;
		forever begin
			@(negedge clk);
			if (!rst && sl_arb_request && !hold_grant) begin
				repeat ($unsigned($random(arb_seed)) % 5) @(posedge clk);
				@(posedge clk);
				sl_arb_grant <= 1'b1;
				left = 1;
				first = 1'b1;
				while (left > 0) begin
					@(posedge clk);
					sl_data_latch <= 1'b1;
					@(negedge clk);
					b = sl_data;
					got_q.push_back(b);
					left = first ? int'(b) : left - 1;
					first = 1'b0;
					@(posedge clk);
					sl_data_latch <= 1'b0;
				end
				sl_arb_grant <= 1'b0;
				@(negedge clk);
				check_idle(sl_arb_request, "sl_arb_request right after a frame");
			end
		end
	end

	initial begin : compare
		msg_byte_t got;
		forever begin
			@(negedge clk);
			while (got_q.size() > 0) begin
				got = got_q.pop_front();
				if (exp_q.size() == 0) begin
					$display("Reply byte %h arrived at %0t when no reply was due", got, $time);
					$display("Testbench failed");
					$fatal(1);
				end else begin
					check_byte(got, exp_q.pop_front(), "reply byte");
				end
			end
		end
	end

	always @(negedge clk) begin
		if (!rst)
			check_idle(overflow, "overflow");
	end

	initial begin : watchdog
		#(N_FRAMES * 300 * CLK_PERIOD);
		$display("Timeout: the DUT stopped delivering replies and the run was ended");
		$display("Testbench failed");
		$fatal(1);
	end

	initial begin : main_seq
		int i;
		rst = 1'b1;
		generate_nak = 1'b0;
		ma_data_valid = 1'b0;
		ma_frame_valid = 1'b0;
		ma_data = '0;
		sl_arb_grant = 1'b0;
		sl_data_latch = 1'b0;
		hold_grant = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_idle(sl_arb_request, "sl_arb_request after reset");
		for (i = 0; i < 5; i++) begin
			run_request(i);
			wait_replies_done();
		end
		for (i = 0; i < N_RANDOM; i++) begin
			run_request($unsigned($random(seed)) % 5);
			wait_replies_done();
		end
		// Twelve reply bytes pile up while the grant is withheld
		hold_grant = 1'b1;
		run_request(1);
		run_request(3);
		run_request(0);
		run_request(2);
		repeat (20) @(negedge clk);
		hold_grant = 1'b0;
		wait_replies_done();
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* basics.f */
+incdir+source
source/basics_pkg.sv
source/ack_generator.sv
source/message_fifo.sv
source/basics_responder.sv
source/basics_node.sv
verif/basics_tb.sv

/* Bender.yml */
package:
  name: basics

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/basics_pkg.sv
      - source/ack_generator.sv
      - source/message_fifo.sv
      - source/basics_responder.sv
      - source/basics_node.sv

  - target: test
    include_dirs:
      - source
    files:
      - verif/basics_tb.sv
